/* Bender.yml */
package:
  name: pkt_gen

sources:
  - verilog/pkt_gen_pkg.sv
  - verilog/beat_fifo.sv
  - verilog/gen_ctrl.sv
  - verilog/tx_stats.sv
  - verilog/cfg_regs.sv
  - verilog/pkt_gen_top.sv
  - target: test
    files:
      - verification/pkt_gen_tb.sv

/* pkt_gen.f */
verilog/pkt_gen_pkg.sv
verilog/beat_fifo.sv
verilog/gen_ctrl.sv
verilog/tx_stats.sv
verilog/cfg_regs.sv
verilog/pkt_gen_top.sv
verification/pkt_gen_tb.sv

/* verification/pkt_gen_tb.sv */
// testbench for the packet generator
// forwarding, discard, configuration, template replay with stamping,
// priority in the gap, statistics and soft reset

`timescale 1ns/1ps

module pkt_gen_tb;

	localparam int                    TIMEOUT_CYCLES = 6000;
	localparam int                    TMPL_BEATS     = 8;
	localparam logic [3:0]            TMPL_TAIL_VB   = 4'd9;
	localparam logic [31:0]           LFSR_MASK      = 32'h8020_0003;
	localparam pkt_gen_pkg::tstamp_t  TSTAMP         = 32'h5eed_1234;
	localparam logic [7:0]            REMOTE_MID     = 8'd5;

	logic                    clk;
	logic                    rst_n;
	pkt_gen_pkg::pkt_beat_t  fwd_in;
	logic                    fwd_in_wr;
	logic                    ram_rd;
	pkt_gen_pkg::tmpl_addr_t ram_addr;
	pkt_gen_pkg::pkt_beat_t  ram_rdata;
	pkt_gen_pkg::pkt_beat_t  pkt_out;
	logic                    pkt_out_wr;
	pkt_gen_pkg::pkt_beat_t  cfg_in;
	logic                    cfg_in_wr;
	pkt_gen_pkg::pkt_beat_t  cfg_out;
	logic                    cfg_out_wr;
	logic                    start;
	pkt_gen_pkg::run_time_t  run_cycles;
	pkt_gen_pkg::tstamp_t    timestamp;

	pkt_gen_pkg::pkt_beat_t  tmpl [128];
	pkt_gen_pkg::tmpl_addr_t rd_addr;
	pkt_gen_pkg::pkt_beat_t  out_q [$];
	pkt_gen_pkg::pkt_beat_t  cfg_q [$];
	pkt_gen_pkg::pkt_beat_t  exp_q [$];
	logic [31:0]             lfsr;
	int                      cycle_cnt;
	int                      start_cyc;
	int                      last_out_cyc;
	pkt_gen_pkg::stat_t      gen_bytes;
	pkt_gen_pkg::stat_t      gen_pkts;

	pkt_gen_top u_pkt_gen_top (.*);

	always #20 clk = ~clk;

	// template RAM with a one cycle read
	always @(posedge clk) begin
		if (ram_rd) begin
			rd_addr = ram_addr;
			#2;
			ram_rdata = tmpl[rd_addr];
		end
	end

	// output monitor sampled mid cycle
	always @(negedge clk) begin
		if (rst_n && pkt_out_wr) begin
			out_q.push_back(pkt_out);
			last_out_cyc = cycle_cnt;
		end
		if (rst_n && cfg_out_wr) begin
			cfg_q.push_back(cfg_out);
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
			stop_failed();
		end
	end

	// ******************************
	// helpers
	// ******************************
	task automatic stop_failed();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_beat(input string name, input pkt_gen_pkg::pkt_beat_t exp,
			input pkt_gen_pkg::pkt_beat_t act);
		if (act !== exp) begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_stat(input string name, input pkt_gen_pkg::stat_t exp,
			input pkt_gen_pkg::stat_t act);
		if (act !== exp) begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
			stop_failed();
		end
	endtask

	// galois LFSR stepped once per bit
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[126:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic pkt_gen_pkg::pkt_beat_t ctrl_head(input logic [2:0] cmd,
			input logic [7:0] src, input logic [7:0] dst,
			input pkt_gen_pkg::reg_addr_t addr, input logic [31:0] value,
			input logic [31:0] filler);
		pkt_gen_pkg::pkt_beat_t b;
		b.pos    = pkt_gen_pkg::POS_HEAD;
		b.vbytes = 4'd0;
		b.data   = '0;
		b.data[pkt_gen_pkg::CMD_LSB +: 3]     = cmd;
		b.data[pkt_gen_pkg::SRC_MID_LSB +: 8] = src;
		b.data[pkt_gen_pkg::DST_MID_LSB +: 8] = dst;
		b.data[pkt_gen_pkg::ADDR_LSB +: 32]   = addr;
		b.data[pkt_gen_pkg::VALUE_LSB +: 32]  = value;
		b.data[32 +: 32]                      = filler;
		return b;
	endfunction

	function automatic pkt_gen_pkg::pkt_beat_t ctrl_tail();
		pkt_gen_pkg::pkt_beat_t b;
		b.pos    = pkt_gen_pkg::POS_TAIL;
		b.vbytes = 4'd8;
		b.data   = rand_bits(128);
		return b;
	endfunction

	// template beat as it should leave with the stamp in beat 5
	function automatic pkt_gen_pkg::pkt_beat_t tmpl_expect(input int idx, input int k);
		pkt_gen_pkg::pkt_beat_t b;
		b = tmpl[idx];
		if (idx == pkt_gen_pkg::STAMP_INDEX) begin
			b.data = {pkt_gen_pkg::stat_t'(k), TSTAMP, 32'hffff_ffff};
		end
		return b;
	endfunction

	task automatic send_fwd_beat(input pkt_gen_pkg::pkt_beat_t b);
		@(posedge clk);
		#2;
		fwd_in    = b;
		fwd_in_wr = 1'b1;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#2;
		fwd_in_wr = 1'b0;
		cfg_in_wr = 1'b0;
	endtask

	task automatic push_fwd_pkt(input int nbeats);
		pkt_gen_pkg::pkt_beat_t b;
		logic [127:0]           r;
		for (int i = 0; i < nbeats; i++) begin
			r        = rand_bits(4);
			b.pos    = (i == 0) ? pkt_gen_pkg::POS_HEAD :
				(i == nbeats - 1) ? pkt_gen_pkg::POS_TAIL : pkt_gen_pkg::POS_MID;
			b.vbytes = (b.pos == pkt_gen_pkg::POS_TAIL) ? r[3:0] : 4'd0;
			b.data   = rand_bits(128);
			exp_q.push_back(b);
			send_fwd_beat(b);
		end
	endtask

	task automatic check_fwd_out(input string name);
		while (out_q.size() < exp_q.size()) @(negedge clk);
		repeat (4) @(negedge clk);
		if (out_q.size() != exp_q.size()) begin
			$display("%s: %0d beats came out, %0d expected", name, out_q.size(), exp_q.size());
			stop_failed();
		end
		while (exp_q.size() > 0) begin
			check_beat(name, exp_q.pop_front(), out_q.pop_front());
		end
	endtask

	task automatic send_cfg_pkt(input pkt_gen_pkg::pkt_beat_t head,
			input pkt_gen_pkg::pkt_beat_t tail);
		@(posedge clk);
		#2;
		cfg_in    = head;
		cfg_in_wr = 1'b1;
		@(posedge clk);
		#2;
		cfg_in    = tail;
		drive_idle();
	endtask

	task automatic cfg_exchange(input string name, input pkt_gen_pkg::pkt_beat_t head,
			input pkt_gen_pkg::pkt_beat_t tail, input pkt_gen_pkg::pkt_beat_t exp_head);
		send_cfg_pkt(head, tail);
		while (cfg_q.size() < 2) @(negedge clk);
		check_beat(name, exp_head, cfg_q.pop_front());
		check_beat(name, tail, cfg_q.pop_front());
	endtask

	task automatic write_reg(input pkt_gen_pkg::reg_addr_t addr, input logic [31:0] value);
		send_cfg_pkt(ctrl_head(pkt_gen_pkg::CMD_WRITE, REMOTE_MID, pkt_gen_pkg::LOCAL_MID,
			addr, value, 32'd0), ctrl_tail());
		repeat (3) @(negedge clk);
		if (cfg_q.size() != 0) begin
			$display("register write to %h came out on cfg_out", addr);
			stop_failed();
		end
	endtask

	task automatic read_reg(input pkt_gen_pkg::reg_addr_t addr, output logic [31:0] value);
		pkt_gen_pkg::pkt_beat_t reply;
		send_cfg_pkt(ctrl_head(pkt_gen_pkg::CMD_READ, REMOTE_MID, pkt_gen_pkg::LOCAL_MID,
			addr, 32'd0, 32'd0), ctrl_tail());
		while (cfg_q.size() < 2) @(negedge clk);
		reply = cfg_q.pop_front();
		void'(cfg_q.pop_front());
		value = reply.data[pkt_gen_pkg::VALUE_LSB +: 32];
	endtask

	task automatic pulse_start(input int run);
		@(posedge clk);
		#2;
		start      = 1'b1;
		run_cycles = pkt_gen_pkg::run_time_t'(run);
		start_cyc  = cycle_cnt;
		gen_bytes  = '0;
		gen_pkts   = '0;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	// done has no pin and shows as a silent output
	task automatic wait_quiet(input int n, input string name, input int run);
		int idle;
		idle = 0;
		while (idle < n) begin
			@(negedge clk);
			idle = pkt_out_wr ? 0 : idle + 1;
		end
		if (last_out_cyc - start_cyc > run + 16) begin
			$display("%s: output went on %0d cycles after start", name,
				last_out_cyc - start_cyc);
			stop_failed();
		end
		if (ram_rd !== 1'b0) begin
			$display("%s: template RAM still being read after the run ended", name);
			stop_failed();
		end
	endtask

	task automatic check_template_pkt(input string name, input int k);
		pkt_gen_pkg::pkt_beat_t e;
		for (int i = 0; i < TMPL_BEATS; i++) begin
			e = tmpl_expect(i, k);
			check_beat(name, e, out_q.pop_front());
			gen_bytes += (e.pos == pkt_gen_pkg::POS_TAIL) ? pkt_gen_pkg::stat_t'(e.vbytes) :
				pkt_gen_pkg::stat_t'(pkt_gen_pkg::BEAT_BYTES);
		end
		gen_pkts += 1;
	endtask

	task automatic read_stats_check(input string name);
		logic [31:0] lo;
		logic [31:0] hi;
		read_reg(pkt_gen_pkg::REG_BYTES_LO, lo);
		read_reg(pkt_gen_pkg::REG_BYTES_HI, hi);
		check_stat({name, " bytes"}, gen_bytes, {hi, lo});
		read_reg(pkt_gen_pkg::REG_PKTS_LO, lo);
		read_reg(pkt_gen_pkg::REG_PKTS_HI, hi);
		check_stat({name, " packets"}, gen_pkts, {hi, lo});
	endtask

	// ******************************
	// tests
	// ******************************
	task automatic test_forward();
		logic [127:0] r;
		for (int p = 0; p < 6; p++) begin
			r = rand_bits(8);
			push_fwd_pkt(2 + int'(r[7:0] % 8'd5));
		end
		drive_idle();
		check_fwd_out("forward");
	endtask

	task automatic test_discard();
		pkt_gen_pkg::pkt_beat_t b;
		b.vbytes = 4'd0;
		for (int i = 0; i < 3; i++) begin
			b.pos  = (i == 2) ? pkt_gen_pkg::POS_TAIL : pkt_gen_pkg::POS_MID;
			b.data = rand_bits(128);
			send_fwd_beat(b);
		end
		push_fwd_pkt(3);
		drive_idle();
		check_fwd_out("discard");
	endtask

	task automatic test_config();
		pkt_gen_pkg::pkt_beat_t head;
		pkt_gen_pkg::pkt_beat_t exp_head;
		logic [31:0]            filler;
		write_reg(pkt_gen_pkg::REG_GAP, 32'd4);
		filler   = rand_bits(32);
		head     = ctrl_head(pkt_gen_pkg::CMD_READ, REMOTE_MID, pkt_gen_pkg::LOCAL_MID,
			pkt_gen_pkg::REG_GAP, 32'd0, filler);
		exp_head = ctrl_head(pkt_gen_pkg::CMD_REPLY, pkt_gen_pkg::LOCAL_MID, REMOTE_MID,
			pkt_gen_pkg::REG_GAP, 32'd4, filler);
		exp_head.data[pkt_gen_pkg::REPLY_FLAG] = 1'b1;
		cfg_exchange("cfg read gap", head, ctrl_tail(), exp_head);
		// unmapped address reads as all ones
		head     = ctrl_head(pkt_gen_pkg::CMD_READ, REMOTE_MID, pkt_gen_pkg::LOCAL_MID,
			32'h0000_0abc, 32'd0, filler);
		exp_head = ctrl_head(pkt_gen_pkg::CMD_REPLY, pkt_gen_pkg::LOCAL_MID, REMOTE_MID,
			32'h0000_0abc, 32'hffff_ffff, filler);
		exp_head.data[pkt_gen_pkg::REPLY_FLAG] = 1'b1;
		cfg_exchange("cfg read unmapped", head, ctrl_tail(), exp_head);
		head = ctrl_head(pkt_gen_pkg::CMD_WRITE, REMOTE_MID, 8'd7, pkt_gen_pkg::REG_GAP,
			32'd999, filler);
		cfg_exchange("cfg pass through", head, ctrl_tail(), head);
	endtask

	// gap of 4 left by the configuration test
	task automatic test_replay();
		int npkts;
		pulse_start(60);
		wait_quiet(60, "replay", 60);
		if (out_q.size() < 2 * TMPL_BEATS || out_q.size() % TMPL_BEATS != 0) begin
			$display("replay: %0d beats out, not whole template packets", out_q.size());
			stop_failed();
		end
		npkts = out_q.size() / TMPL_BEATS;
		for (int k = 0; k < npkts; k++) begin
			check_template_pkt("replay", k);
		end
		read_stats_check("replay stats");
	endtask

	task automatic test_restart_priority();
		int npkts;
		write_reg(pkt_gen_pkg::REG_SOFT_RST, 32'd1);
		write_reg(pkt_gen_pkg::REG_SOFT_RST, 32'd0);
		write_reg(pkt_gen_pkg::REG_GAP, 32'd30);
		pulse_start(100);
		// forwarded packet lands in the first gap
		while (out_q.size() < TMPL_BEATS) @(negedge clk);
		push_fwd_pkt(3);
		drive_idle();
		wait_quiet(60, "priority", 100);
		if (out_q.size() < 2 * TMPL_BEATS + 3 || (out_q.size() - 3) % TMPL_BEATS != 0) begin
			$display("priority: %0d beats out, packets not whole", out_q.size());
			stop_failed();
		end
		npkts = (out_q.size() - 3) / TMPL_BEATS;
		check_template_pkt("priority", 0);
		while (exp_q.size() > 0) begin
			check_beat("priority forward", exp_q.pop_front(), out_q.pop_front());
		end
		for (int k = 1; k < npkts; k++) begin
			check_template_pkt("priority", k);
		end
		read_stats_check("restart stats");
	endtask

	initial begin
		lfsr         = 32'h0501_9f04;
		clk          = 1'b0;
		rst_n        = 1'b0;
		fwd_in       = '0;
		fwd_in_wr    = 1'b0;
		cfg_in       = '0;
		cfg_in_wr    = 1'b0;
		start        = 1'b0;
		run_cycles   = '0;
		timestamp    = TSTAMP;
		ram_rdata    = '0;
		rd_addr      = '0;
		cycle_cnt    = 0;
		start_cyc    = 0;
		last_out_cyc = 0;
		gen_bytes    = '0;
		gen_pkts     = '0;
		// head, six middle beats, tail; data spread over the whole address
		for (int a = 0; a < 128; a++) begin
			tmpl[a].pos    = (a == 0) ? pkt_gen_pkg::POS_HEAD :
				(a == TMPL_BEATS - 1) ? pkt_gen_pkg::POS_TAIL : pkt_gen_pkg::POS_MID;
			tmpl[a].vbytes = (a == TMPL_BEATS - 1) ? TMPL_TAIL_VB : 4'd0;
			tmpl[a].data   = {32'(a) * 32'h9e37_79b9, ~32'(a), 32'(a) ^ 32'h5a5a_5a5a,
				32'h7e11_0000 + 32'(a)};
		end
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		test_forward();
		test_discard();
		test_config();
		test_replay();
		test_restart_priority();

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* verilog/beat_fifo.sv */
// beat FIFO for forwarded traffic
// circular buffer that shows the oldest beat without a read cycle (first word fall through)
// a write into a full buffer is dropped

`timescale 1ns/1ps

module beat_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pkt_gen_pkg::pkt_beat_t wr_beat,
	input  logic                  wr,
	input  logic                  rd,
	output pkt_gen_pkg::pkt_beat_t head,
	output logic                  empty
);

	pkt_gen_pkg::pkt_beat_t mem [pkt_gen_pkg::FIFO_DEPTH];

	logic [pkt_gen_pkg::FIFO_AW-1:0] wr_ptr;
	logic [pkt_gen_pkg::FIFO_AW-1:0] rd_ptr;
	logic [pkt_gen_pkg::FIFO_AW:0]   count;
	logic                            full;
	logic                            do_wr;
	logic                            do_rd;

	assign full  = (count == (pkt_gen_pkg::FIFO_AW+1)'(pkt_gen_pkg::FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign head = mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_beat;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verilog/cfg_regs.sv */
// configuration registers on the control bus
// two-beat control packets for this module id write or read registers;
// writes are consumed, reads turn into replies, other traffic passes
// through with one cycle of latency

`timescale 1ns/1ps

module cfg_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pkt_gen_pkg::pkt_beat_t cfg_in,
	input  logic                  cfg_in_wr,
	output pkt_gen_pkg::pkt_beat_t cfg_out,
	output logic                  cfg_out_wr,
	input  pkt_gen_pkg::stat_t     bytes,
	input  pkt_gen_pkg::stat_t     pkts,
	output pkt_gen_pkg::gap_t      gap,
	output logic                  soft_rst
);

	logic                   is_head;
	logic                   is_tail;
	logic                   is_local;
	logic                   wr_hit;
	logic                   rd_hit;
	logic                   suppress;
	logic                   write_flag;
	logic [2:0]             cmd;
	pkt_gen_pkg::reg_addr_t addr;
	logic [31:0]            rd_value;
	pkt_gen_pkg::pkt_beat_t reply;

	// ******************************
	// head decode
	// ******************************
	assign is_head  = cfg_in_wr && cfg_in.pos == pkt_gen_pkg::POS_HEAD;
	assign is_tail  = cfg_in_wr && cfg_in.pos == pkt_gen_pkg::POS_TAIL;
	assign cmd      = cfg_in.data[pkt_gen_pkg::CMD_LSB +: 3];
	assign addr     = cfg_in.data[pkt_gen_pkg::ADDR_LSB +: 32];
	assign is_local = cfg_in.data[pkt_gen_pkg::DST_MID_LSB +: 8] == pkt_gen_pkg::LOCAL_MID;
	assign wr_hit   = is_head && is_local && cmd == pkt_gen_pkg::CMD_WRITE;
	assign rd_hit   = is_head && is_local && cmd == pkt_gen_pkg::CMD_READ;

	// write head and its tail never leave
	assign suppress = wr_hit || (is_tail && write_flag);

	always_comb begin
		case (addr)
			pkt_gen_pkg::REG_SOFT_RST: rd_value = {31'd0, soft_rst};
			pkt_gen_pkg::REG_GAP:      rd_value = gap;
			pkt_gen_pkg::REG_BYTES_LO: rd_value = bytes[31:0];
			pkt_gen_pkg::REG_BYTES_HI: rd_value = bytes[63:32];
			pkt_gen_pkg::REG_PKTS_LO:  rd_value = pkts[31:0];
			pkt_gen_pkg::REG_PKTS_HI:  rd_value = pkts[63:32];
			default:                   rd_value = pkt_gen_pkg::READ_DEFAULT;
		endcase
	end

	// read reply with flag, command, swapped ids and value
	always_comb begin
		reply = cfg_in;
		reply.data[pkt_gen_pkg::REPLY_FLAG]          = 1'b1;
		reply.data[pkt_gen_pkg::CMD_LSB +: 3]        = pkt_gen_pkg::CMD_REPLY;
		reply.data[pkt_gen_pkg::SRC_MID_LSB +: 8]    = cfg_in.data[pkt_gen_pkg::DST_MID_LSB +: 8];
		reply.data[pkt_gen_pkg::DST_MID_LSB +: 8]    = cfg_in.data[pkt_gen_pkg::SRC_MID_LSB +: 8];
		reply.data[pkt_gen_pkg::VALUE_LSB +: 32]     = rd_value;
	end

	// ******************************
	// registers and output
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			soft_rst   <= 1'b0;
			gap        <= '0;
			write_flag <= 1'b0;
			cfg_out_wr <= 1'b0;
		end else begin
			cfg_out_wr <= cfg_in_wr && !suppress;
			if (is_head) begin
				write_flag <= wr_hit;
			end else if (is_tail) begin
				write_flag <= 1'b0;
			end
			if (wr_hit) begin
				case (addr)
					pkt_gen_pkg::REG_SOFT_RST: soft_rst <= cfg_in.data[0];
					pkt_gen_pkg::REG_GAP:      gap <= cfg_in.data[pkt_gen_pkg::VALUE_LSB +: 32];
					default:                   ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		cfg_out <= rd_hit ? reply : cfg_in;
	end

endmodule

/* verilog/gen_ctrl.sv */
// packet sequencer
// forwards FIFO packets, drops headless streams and replays the template
// packet from the external RAM with a programmable gap, until the run
// budget is spent; beat 5 of each replayed packet carries a stamp

`timescale 1ns/1ps

module gen_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  pkt_gen_pkg::run_time_t  run_cycles,
	input  pkt_gen_pkg::tstamp_t    timestamp,
	input  pkt_gen_pkg::pkt_beat_t  fifo_head,
	input  logic                   fifo_empty,
	output logic                   fifo_rd,
	output logic                   ram_rd,
	output pkt_gen_pkg::tmpl_addr_t ram_addr,
	input  pkt_gen_pkg::pkt_beat_t  ram_rdata,
	output pkt_gen_pkg::pkt_beat_t  pkt_out,
	output logic                   pkt_out_wr,
	output pkt_gen_pkg::tx_event_t  ev,
	output logic                   stats_clear,
	input  pkt_gen_pkg::stat_t      pkts,
	input  pkt_gen_pkg::gap_t       gap,
	input  logic                   soft_rst
);

	typedef enum logic [2:0] {
		S_IDLE, S_DISCARD, S_FORWARD, S_FETCH, S_REPLAY, S_GAP, S_DONE
	} state_t;

	state_t                 state;
	state_t                 ret_state;
	logic                   in_run;
	logic                   out_gen;
	logic                   run_over;
	logic                   take_ok;
	logic                   fwd_emit;
	pkt_gen_pkg::run_time_t run_cnt;
	pkt_gen_pkg::run_time_t run_budget;
	pkt_gen_pkg::gap_t      gap_cnt;
	pkt_gen_pkg::tmpl_addr_t beat_idx;
	pkt_gen_pkg::pkt_beat_t replay_beat;

	// where a FIFO head leads when picked up in idle or gap
	function automatic state_t pick_state(input pkt_gen_pkg::pos_t pos, input state_t stay);
		if (pos == pkt_gen_pkg::POS_HEAD) begin
			return S_FORWARD;
		end else if (pos == pkt_gen_pkg::POS_TAIL) begin
			return stay;
		end
		return S_DISCARD;
	endfunction

	assign ret_state = in_run ? S_GAP : S_IDLE;
	assign run_over  = (run_cnt >= run_budget);

	// ******************************
	// FIFO side decode
	// ******************************
	always_comb begin
		case (state)
			S_IDLE:              take_ok = !start;
			S_GAP:               take_ok = !run_over;
			S_FORWARD, S_DISCARD: take_ok = 1'b1;
			default:             take_ok = 1'b0;
		endcase
	end

	assign fifo_rd  = take_ok && !fifo_empty;
	assign fwd_emit = fifo_rd && (state == S_FORWARD ||
		((state == S_IDLE || state == S_GAP) && fifo_head.pos == pkt_gen_pkg::POS_HEAD));

	// RAM data lags the address by one beat
	assign beat_idx = ram_addr - 1'b1;

	always_comb begin
		replay_beat = ram_rdata;
		if (beat_idx == pkt_gen_pkg::tmpl_addr_t'(pkt_gen_pkg::STAMP_INDEX) &&
				ram_rdata.pos == pkt_gen_pkg::POS_MID) begin
			replay_beat.data = {pkts, timestamp, 32'hffff_ffff};
		end
	end

	assign ev = '{beat: pkt_out, wr: pkt_out_wr, generated: out_gen};

	// ******************************
	// main FSM
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			in_run      <= 1'b0;
			ram_rd      <= 1'b0;
			ram_addr    <= '0;
			pkt_out     <= '0;
			pkt_out_wr  <= 1'b0;
			out_gen     <= 1'b0;
			stats_clear <= 1'b0;
			run_cnt     <= '0;
			run_budget  <= '0;
			gap_cnt     <= '0;
		end else begin
			pkt_out_wr  <= 1'b0;
			stats_clear <= 1'b0;
			if (in_run) begin
				run_cnt <= run_cnt + 1'b1;
			end
			if (gap_cnt != '1) begin
				gap_cnt <= gap_cnt + 1'b1;
			end

			if (fwd_emit) begin
				pkt_out    <= fifo_head;
				pkt_out_wr <= 1'b1;
				out_gen    <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (start) begin
						in_run      <= 1'b1;
						run_cnt     <= '0;
						run_budget  <= run_cycles;
						stats_clear <= 1'b1;
						ram_rd      <= 1'b1;
						ram_addr    <= '0;
						state       <= S_FETCH;
					end else if (fifo_rd) begin
						state <= pick_state(fifo_head.pos, S_IDLE);
					end
				end
				S_DISCARD: begin
					if (fifo_rd && fifo_head.pos == pkt_gen_pkg::POS_TAIL) begin
						state <= ret_state;
					end
				end
				S_FORWARD: begin
					if (fwd_emit && fifo_head.pos == pkt_gen_pkg::POS_TAIL) begin
						state <= ret_state;
					end
				end
				S_FETCH: begin
					ram_rd   <= 1'b1;
					ram_addr <= ram_addr + 1'b1;
					state    <= S_REPLAY;
				end
				S_REPLAY: begin
					pkt_out    <= replay_beat;
					pkt_out_wr <= 1'b1;
					out_gen    <= 1'b1;
					if (ram_rdata.pos == pkt_gen_pkg::POS_TAIL) begin
						ram_rd   <= 1'b0;
						ram_addr <= '0;
						gap_cnt  <= '0;
						if (run_over) begin
							in_run <= 1'b0;
							state  <= S_DONE;
						end else begin
							state <= S_GAP;
						end
					end else begin
						ram_addr <= ram_addr + 1'b1;
					end
				end
				S_GAP: begin
					if (run_over) begin
						in_run <= 1'b0;
						state  <= S_DONE;
					end else if (fifo_rd) begin
						state <= pick_state(fifo_head.pos, S_GAP);
					end else if (gap_cnt >= gap) begin
						ram_rd   <= 1'b1;
						ram_addr <= '0;
						state    <= S_FETCH;
					end
				end
				S_DONE: begin
					if (soft_rst) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* verilog/pkt_gen_pkg.sv */
// packet generator shared definitions
// beat layout, control packet fields, register map and sizing constants

package pkt_gen_pkg;

	// ******************************
	// beat format
	// ******************************
	typedef logic [1:0] pos_t;

	localparam pos_t POS_HEAD = 2'b01;
	localparam pos_t POS_MID  = 2'b11;
	localparam pos_t POS_TAIL = 2'b10;

	// 134 bits with the position marker on top
	typedef struct packed {
		pos_t         pos;
		logic [3:0]   vbytes;
		logic [127:0] data;
	} pkt_beat_t;

	typedef logic [6:0]  tmpl_addr_t;
	typedef logic [63:0] run_time_t;
	typedef logic [31:0] gap_t;
	typedef logic [63:0] stat_t;
	typedef logic [31:0] tstamp_t;
	typedef logic [31:0] reg_addr_t;

	// one beat as seen by the statistics block
	typedef struct packed {
		pkt_beat_t beat;
		logic      wr;
		logic      generated;
	} tx_event_t;

	// ******************************
	// control packet fields
	// ******************************
	localparam int CMD_LSB     = 124;
	localparam int SRC_MID_LSB = 104;
	localparam int DST_MID_LSB = 96;
	localparam int ADDR_LSB    = 64;
	localparam int VALUE_LSB   = 0;
	localparam int REPLY_FLAG  = 127;

	localparam logic [2:0] CMD_WRITE = 3'b010;
	localparam logic [2:0] CMD_READ  = 3'b001;
	localparam logic [2:0] CMD_REPLY = 3'b011;

	localparam logic [7:0] LOCAL_MID = 8'd62;

	// register map
	localparam reg_addr_t REG_SOFT_RST = 32'h0000_0000;
	localparam reg_addr_t REG_GAP      = 32'h0001_0001;
	localparam reg_addr_t REG_BYTES_LO = 32'h0000_0003;
	localparam reg_addr_t REG_BYTES_HI = 32'h0000_0004;
	localparam reg_addr_t REG_PKTS_LO  = 32'h0000_0005;
	localparam reg_addr_t REG_PKTS_HI  = 32'h0000_0006;

	localparam logic [31:0] READ_DEFAULT = 32'hffff_ffff;

	// ******************************
	// sizing
	// ******************************
	localparam int STAMP_INDEX = 5;
	localparam int FIFO_DEPTH  = 64;
	localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
	localparam int BEAT_BYTES  = 16;

endpackage

/* verilog/pkt_gen_top.sv */
// packet generator top level
// forward FIFO, sequencer, statistics and configuration registers

`timescale 1ns/1ps

module pkt_gen_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  pkt_gen_pkg::pkt_beat_t  fwd_in,
	input  logic                   fwd_in_wr,
	output logic                   ram_rd,
	output pkt_gen_pkg::tmpl_addr_t ram_addr,
	input  pkt_gen_pkg::pkt_beat_t  ram_rdata,
	output pkt_gen_pkg::pkt_beat_t  pkt_out,
	output logic                   pkt_out_wr,
	input  pkt_gen_pkg::pkt_beat_t  cfg_in,
	input  logic                   cfg_in_wr,
	output pkt_gen_pkg::pkt_beat_t  cfg_out,
	output logic                   cfg_out_wr,
	input  logic                   start,
	input  pkt_gen_pkg::run_time_t  run_cycles,
	input  pkt_gen_pkg::tstamp_t    timestamp
);

	pkt_gen_pkg::pkt_beat_t fifo_head;
	logic                   fifo_empty;
	logic                   fifo_rd;
	pkt_gen_pkg::tx_event_t ev;
	logic                   stats_clear;
	pkt_gen_pkg::stat_t     bytes;
	pkt_gen_pkg::stat_t     pkts;
	pkt_gen_pkg::gap_t      gap;
	logic                   soft_rst;

	beat_fifo u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_beat (fwd_in),
		.wr      (fwd_in_wr),
		.rd      (fifo_rd),
		.head    (fifo_head),
		.empty   (fifo_empty)
	);

	gen_ctrl u_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.run_cycles  (run_cycles),
		.timestamp   (timestamp),
		.fifo_head   (fifo_head),
		.fifo_empty  (fifo_empty),
		.fifo_rd     (fifo_rd),
		.ram_rd      (ram_rd),
		.ram_addr    (ram_addr),
		.ram_rdata   (ram_rdata),
		.pkt_out     (pkt_out),
		.pkt_out_wr  (pkt_out_wr),
		.ev          (ev),
		.stats_clear (stats_clear),
		.pkts        (pkts),
		.gap         (gap),
		.soft_rst    (soft_rst)
	);

	tx_stats u_stats (
		.clk   (clk),
		.rst_n (rst_n),
		.ev    (ev),
		.clear (stats_clear),
		.bytes (bytes),
		.pkts  (pkts)
	);

	cfg_regs u_cfg (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_in     (cfg_in),
		.cfg_in_wr  (cfg_in_wr),
		.cfg_out    (cfg_out),
		.cfg_out_wr (cfg_out_wr),
		.bytes      (bytes),
		.pkts       (pkts),
		.gap        (gap),
		.soft_rst   (soft_rst)
	);

endmodule

/* verilog/tx_stats.sv */
// statistics for generated traffic
// byte count per beat and packet count per tail for template beats only

`timescale 1ns/1ps

module tx_stats (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pkt_gen_pkg::tx_event_t ev,
	input  logic                  clear,
	output pkt_gen_pkg::stat_t     bytes,
	output pkt_gen_pkg::stat_t     pkts
);

	pkt_gen_pkg::stat_t add_bytes;
	logic               count_it;

	assign count_it = ev.wr && ev.generated;

	// full beats carry 16 bytes and the tail says how many
	always_comb begin
		case (ev.beat.pos)
			pkt_gen_pkg::POS_HEAD,
			pkt_gen_pkg::POS_MID:  add_bytes = pkt_gen_pkg::stat_t'(pkt_gen_pkg::BEAT_BYTES);
			pkt_gen_pkg::POS_TAIL: add_bytes = pkt_gen_pkg::stat_t'(ev.beat.vbytes);
			default:               add_bytes = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bytes <= '0;
			pkts  <= '0;
		end else if (clear) begin
			bytes <= '0;
			pkts  <= '0;
		end else if (count_it) begin
			bytes <= bytes + add_bytes;
			if (ev.beat.pos == pkt_gen_pkg::POS_TAIL) begin
				pkts <= pkts + 1'b1;
			end
		end
	end

endmodule
